// File: src.f
+incdir+common
common/cnn_pkg.sv
source/window_addr_gen.sv
source/window_buffer.sv
source/conv3x3_mac.sv
source/maxpool2x2.sv
source/layer_ctrl.sv
source/cnn_engine_top.sv
verification/cnn_engine_asserts.sv
verification/cnn_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cnn_engine_tb \
    -f src.f --Mdir obj_dir -o sim_cnn
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_cnn +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0

// File: verification/cnn_engine_tb.sv
`default_nettype none

`include "cnn_cfg.svh"

module cnn_engine_tb
    import cnn_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS     = `CNN_IMG_BASE + 10 * `CNN_ROW_STRIDE;
    localparam int RUN_WRITES    = 64 + 16 + 4 + 1;
    localparam int RUN_READS     = (2 + 68) * `CNN_KERNEL_TAPS + 17 * `CNN_POOL_TAPS;
    // five runs at 5 cycles per access in the worst case
    localparam int CYCLE_LIMIT   = 5 * (5 * (RUN_READS + RUN_WRITES) + 200) + 100;
    // well inside the first conv pass, after its first writes
    localparam int SECOND_START  = 1000;
    localparam int FILL_SMALL    = 0;
    localparam int FILL_LARGE    = 1;
    localparam int FILL_NEGATIVE = 2;

    logic     CLK;
    logic     rst;
    logic     start;
    logic     mem_ack;
    pixel_t   mem_rdata;
    mem_req_t mem_req;
    logic     busy;
    logic     done;
    pixel_t   mem [MEM_WORDS];
    pixel_t   model [MEM_WORDS];
    int       checks = 0;
    int       errors = 0;
    int       tests = 0;
    int       cycle_count = 0;

    cnn_engine_top UUT (
        .CLK         (CLK),
        .rst_i       (rst),
        .start_i     (start),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata),
        .mem_req_o   (mem_req),
        .busy_o      (busy),
        .done_o      (done)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("engine never signalled done within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
    endtask

    // strobe, busy and done all stay low
    task automatic expect_idle(input string what, input int cycles);
        repeat (cycles) begin
            @(negedge CLK);
            check_value(what, 32'({mem_req.stb, busy, done}), 32'd0);
        end
    endtask

    task automatic fill_memory(input int mode);
        for (int i = 0; i < MEM_WORDS; i++) begin
            case (mode)
                FILL_LARGE: mem[i] = pixel_t'($urandom);
                FILL_SMALL: mem[i] = pixel_t'(int'($urandom_range(15, 0)) - 8);
                default: begin
                    // positive kernels keep every layer negative
                    if (i < `CNN_IMG_BASE)
                        mem[i] = pixel_t'($urandom_range(3, 1));
                    else
                        mem[i] = pixel_t'(-int'($urandom_range(40, 1)));
                end
            endcase
        end
    endtask

    function automatic int img_index(input int row, input int col);
        return `CNN_IMG_BASE + row * `CNN_ROW_STRIDE + col;
    endfunction

    // each result lands on the window's top-left pixel
    task automatic model_conv(input int kernel_base, input int last);
        logic signed [31:0] prod;
        pixel_t             acc;
        for (int r = 0; r <= last; r++) begin
            for (int c = 0; c <= last; c++) begin
                acc = '0;
                for (int k = 0; k < 9; k++) begin
                    prod = $signed(model[kernel_base + k])
                         * $signed(model[img_index(r + k / 3, c + k % 3)]);
                    acc  = acc + prod[15:0];
                end
                model[img_index(r, c)] = acc;
            end
        end
    endtask

    task automatic model_pool(input int last);
        pixel_t best;
        pixel_t v;
        for (int r = 0; r <= last; r += 2) begin
            for (int c = 0; c <= last; c += 2) begin
                best = model[img_index(r, c)];
                for (int k = 1; k < 4; k++) begin
                    v = model[img_index(r + k / 2, c + k % 2)];
                    if ($signed(v) > $signed(best))
                        best = v;
                end
                model[img_index(r / 2, c / 2)] = best;
            end
        end
    endtask

    task automatic build_model();
        for (int i = 0; i < MEM_WORDS; i++)
            model[i] = mem[i];
        model_conv(`CNN_KERNEL1_BASE, `CNN_L1_CONV_LAST);
        model_pool(`CNN_L1_POOL_LAST);
        model_conv(`CNN_KERNEL2_BASE, `CNN_L2_CONV_LAST);
        model_pool(`CNN_L2_POOL_LAST);
    endtask

    // start pulse then bus service with random ack delays until done
    task automatic run_engine(input bit extra_start, output int writes);
        int wait_left;
        int cycles;
        int idx;
        writes    = 0;
        wait_left = -1;
        cycles    = 0;
        start     = 1'b1;
        @(negedge CLK);
        while (!done) begin
            start = extra_start && (cycles == SECOND_START);
            if (start)
                check_value("busy at second start", 32'(busy), 32'd1);
            if (mem_ack) begin
                mem_ack = 1'b0;
            end else if (mem_req.stb) begin
                if (wait_left < 0)
                    wait_left = int'($urandom_range(3, 0));
                if (wait_left == 0) begin
                    idx = int'(mem_req.addr);
                    check_value("address in range", 32'(idx < MEM_WORDS), 32'd1);
                    if (mem_req.we) begin
                        mem[idx % MEM_WORDS] = mem_req.wdata;
                        writes++;
                    end else begin
                        mem_rdata = mem[idx % MEM_WORDS];
                    end
                    mem_ack   = 1'b1;
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
            cycles++;
            @(negedge CLK);
        end
        start   = 1'b0;
        mem_ack = 1'b0;
        @(negedge CLK);
    endtask

    task automatic do_run(input int mode, input bit refill, input bit extra_start);
        int writes;
        if (refill)
            fill_memory(mode);
        build_model();
        run_engine(extra_start, writes);
        check_value("write acks per run", 32'(writes), 32'(RUN_WRITES));
        for (int i = 0; i < MEM_WORDS; i++)
            check_value($sformatf("word %0d", i), 32'(mem[i]), 32'(model[i]));
    endtask

    initial begin
        int errors_before;
        void'($urandom(32'h73f9_a066));
        CLK       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        repeat (2) @(negedge CLK);
        rst = 1'b0;

        errors_before = errors;
        expect_idle("outputs after reset", 10);
        report_test("reset quiet", errors_before);

        errors_before = errors;
        do_run(FILL_SMALL, 1'b1, 1'b0);
        report_test("random full run", errors_before);

        errors_before = errors;
        do_run(FILL_LARGE, 1'b1, 1'b0);
        report_test("overflow wrap", errors_before);

        errors_before = errors;
        do_run(FILL_NEGATIVE, 1'b1, 1'b0);
        check_value("final word sign", 32'(mem[`CNN_IMG_BASE][15]), 32'd1);
        report_test("negative pooling", errors_before);

        // second run works on what the first left in memory
        errors_before = errors;
        do_run(FILL_SMALL, 1'b1, 1'b1);
        expect_idle("outputs after ignored start", 4);
        do_run(FILL_SMALL, 1'b0, 1'b0);
        report_test("repeat and ignored start", errors_before);

        check_value("assertion failures", 32'(UUT.u_ctrl.u_asserts.fail_count), 32'd0);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/cnn_engine_asserts.sv
`default_nettype none

module cnn_engine_asserts
    import cnn_pkg::*;
(
    input wire logic     CLK,
    input wire logic     rst_i,
    input wire logic     mem_ack_i,
    input wire mem_req_t mem_req_o,
    input wire logic     busy_o,
    input wire logic     done_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // request fields hold until the slave answers
    hold_until_ack: assert property (@(posedge CLK) disable iff (rst_i)
        mem_req_o.stb && !mem_ack_i |=> mem_req_o.stb && $stable(mem_req_o.addr)
            && $stable(mem_req_o.we) && (!mem_req_o.we || $stable(mem_req_o.wdata)))
    else begin
        fail_count++;
        $error("bus request changed before ack");
    end

    gap_after_ack: assert property (@(posedge CLK) disable iff (rst_i)
        mem_req_o.stb && mem_ack_i |=> !mem_req_o.stb)
    else begin
        fail_count++;
        $error("strobe high in the cycle after an ack");
    end

    done_one_cycle: assert property (@(posedge CLK) disable iff (rst_i) done_o |=> !done_o)
    else begin
        fail_count++;
        $error("done held longer than one cycle");
    end

    quiet_after_reset: assert property (@(posedge CLK)
        rst_i |=> !busy_o && !mem_req_o.stb && !done_o)
    else begin
        fail_count++;
        $error("controller active right after reset");
    end

endmodule

bind layer_ctrl cnn_engine_asserts u_asserts (.*);

`default_nettype wire

// File: source/cnn_engine_top.sv
`default_nettype none

`include "cnn_cfg.svh"

module cnn_engine_top
    import cnn_pkg::*;
(
    input  wire logic   CLK,
    input  wire logic   rst_i,
    input  wire logic   start_i,
    input  wire logic   mem_ack_i,
    input  wire pixel_t mem_rdata_i,
    output mem_req_t    mem_req_o,
    output logic        busy_o,
    output logic        done_o
);

    win_pos_t  pos;
    addr_sel_e addr_sel;
    tap_t      tap;
    mem_addr_t addr;
    logic      kernel_load;
    logic      window_load;
    pixel_t    conv_result;
    pixel_t    pool_result;
    pixel_t    kernel [`CNN_KERNEL_TAPS];
    pixel_t    window [`CNN_KERNEL_TAPS];

    layer_ctrl u_ctrl (
        .CLK           (CLK),
        .rst_i         (rst_i),
        .start_i       (start_i),
        .mem_ack_i     (mem_ack_i),
        .addr_i        (addr),
        .conv_result_i (conv_result),
        .pool_result_i (pool_result),
        .pos_o         (pos),
        .addr_sel_o    (addr_sel),
        .tap_o         (tap),
        .kernel_load_o (kernel_load),
        .window_load_o (window_load),
        .mem_req_o     (mem_req_o),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    window_addr_gen u_addr (
        .pos_i  (pos),
        .sel_i  (addr_sel),
        .tap_i  (tap),
        .addr_o (addr)
    );

    window_buffer u_buf (
        .CLK           (CLK),
        .kernel_load_i (kernel_load),
        .window_load_i (window_load),
        .tap_i         (tap),
        .rdata_i       (mem_rdata_i),
        .kernel_o      (kernel),
        .window_o      (window)
    );

    conv3x3_mac u_mac (
        .CLK      (CLK),
        .kernel_i (kernel),
        .window_i (window),
        .result_o (conv_result)
    );

    maxpool2x2 u_pool (
        .window_i (window),
        .result_o (pool_result)
    );

endmodule

`default_nettype wire

// File: source/layer_ctrl.sv
`default_nettype none

`include "cnn_cfg.svh"

module layer_ctrl
    import cnn_pkg::*;
(
    input  wire logic      CLK,
    input  wire logic      rst_i,
    input  wire logic      start_i,
    input  wire logic      mem_ack_i,
    input  wire mem_addr_t addr_i,
    input  wire pixel_t    conv_result_i,
    input  wire pixel_t    pool_result_i,
    output win_pos_t       pos_o,
    output addr_sel_e      addr_sel_o,
    output tap_t           tap_o,
    output logic           kernel_load_o,
    output logic           window_load_o,
    output mem_req_t       mem_req_o,
    output logic           busy_o,
    output logic           done_o
);

    ctrl_state_e state_q;
    ctrl_state_e gather_next;
    win_pos_t    pos_q;
    tap_t        tap_q;
    tap_t        last_tap;
    pos_t        pass_last;
    pos_t        step;
    logic        ack_q;
    logic        stb;
    logic        ack;
    logic        col_end;
    logic        pass_end;
    logic        is_write;
    logic        is_gather;

    assign is_write  = (state_q == CONV_WRITE) || (state_q == POOL_WRITE);
    assign is_gather = (state_q == CONV_GATHER) || (state_q == POOL_GATHER);

    // strobe drops for one cycle after every ack
    assign stb = (is_write || is_gather || state_q == LOAD_KERNEL) && !ack_q;
    assign ack = stb && mem_ack_i;

    assign last_tap = (state_q == POOL_GATHER) ? tap_t'(`CNN_POOL_TAPS - 1)
                                               : tap_t'(`CNN_KERNEL_TAPS - 1);

    always_comb begin
        if (state_q == POOL_WRITE) begin
            pass_last = pos_q.layer ? pos_t'(`CNN_L2_POOL_LAST) : pos_t'(`CNN_L1_POOL_LAST);
            step      = pos_t'(2);
        end else begin
            pass_last = pos_q.layer ? pos_t'(`CNN_L2_CONV_LAST) : pos_t'(`CNN_L1_CONV_LAST);
            step      = pos_t'(1);
        end
    end

    assign col_end  = (pos_q.col == pass_last);
    assign pass_end = col_end && (pos_q.row == pass_last);

    always_comb begin
        case (state_q)
            LOAD_KERNEL: gather_next = CONV_GATHER;
            CONV_GATHER: gather_next = CONV_WAIT;
            default:     gather_next = POOL_WRITE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            state_q <= IDLE;
            pos_q   <= '0;
            tap_q   <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= ack;
            // row-major window step after each result write
            if (ack && is_write) begin
                if (!col_end) begin
                    pos_q.col <= pos_q.col + step;
                end else begin
                    pos_q.col <= '0;
                    pos_q.row <= pass_end ? pos_t'(0) : pos_q.row + step;
                end
            end
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= LOAD_KERNEL;
                        pos_q   <= '0;
                        tap_q   <= '0;
                    end
                end
                LOAD_KERNEL, CONV_GATHER, POOL_GATHER: begin
                    if (ack) begin
                        if (tap_q == last_tap) begin
                            tap_q   <= '0;
                            state_q <= gather_next;
                        end else begin
                            tap_q <= tap_q + 1'b1;
                        end
                    end
                end
                // mac register picks up the last tap here
                CONV_WAIT: state_q <= CONV_WRITE;
                CONV_WRITE: begin
                    if (ack) begin
                        state_q <= pass_end ? POOL_GATHER : CONV_GATHER;
                    end
                end
                POOL_WRITE: begin
                    if (ack) begin
                        if (!pass_end) begin
                            state_q <= POOL_GATHER;
                        end else if (!pos_q.layer) begin
                            state_q     <= LOAD_KERNEL;
                            pos_q.layer <= 1'b1;
                        end else begin
                            state_q <= DONE;
                        end
                    end
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_comb begin
        case (state_q)
            CONV_GATHER:           addr_sel_o = CONV_TAP;
            CONV_WAIT, CONV_WRITE: addr_sel_o = CONV_RESULT;
            POOL_GATHER:           addr_sel_o = POOL_TAP;
            POOL_WRITE:            addr_sel_o = POOL_RESULT;
            default:               addr_sel_o = KERNEL_TAP;
        endcase
    end

    assign pos_o         = pos_q;
    assign tap_o         = tap_q;
    assign kernel_load_o = ack && (state_q == LOAD_KERNEL);
    assign window_load_o = ack && is_gather;

    assign mem_req_o.stb   = stb;
    assign mem_req_o.we    = is_write;
    assign mem_req_o.addr  = addr_i;
    assign mem_req_o.wdata = (state_q == POOL_WRITE) ? pool_result_i : conv_result_i;

    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == DONE);

endmodule

`default_nettype wire

// File: source/maxpool2x2.sv
`default_nettype none

`include "cnn_cfg.svh"

module maxpool2x2
    import cnn_pkg::*;
(
    input  wire pixel_t window_i [`CNN_KERNEL_TAPS],
    output pixel_t      result_o
);

    pixel_t upper_max;
    pixel_t lower_max;

    function automatic pixel_t signed_max(input pixel_t a, input pixel_t b);
        return ($signed(a) > $signed(b)) ? a : b;
    endfunction

    // taps 0,1 are the upper row and 2,3 the lower
    assign upper_max = signed_max(window_i[0], window_i[1]);
    assign lower_max = signed_max(window_i[2], window_i[3]);
    assign result_o  = signed_max(upper_max, lower_max);

endmodule

`default_nettype wire

// File: source/conv3x3_mac.sv
`default_nettype none

`include "cnn_cfg.svh"

module conv3x3_mac
    import cnn_pkg::*;
(
    input  wire logic   CLK,
    input  wire pixel_t kernel_i [`CNN_KERNEL_TAPS],
    input  wire pixel_t window_i [`CNN_KERNEL_TAPS],
    output pixel_t      result_o
);

    logic signed [2*`CNN_DATA_W-1:0] products [`CNN_KERNEL_TAPS];
    pixel_t                          sum;

    // full-width signed products
    always_comb begin
        for (int i = 0; i < `CNN_KERNEL_TAPS; i++) begin
            products[i] = $signed(kernel_i[i]) * $signed(window_i[i]);
        end
    end

    // sum wraps at the data width
    always_comb begin
        sum = '0;
        for (int i = 0; i < `CNN_KERNEL_TAPS; i++) begin
            sum = sum + products[i][`CNN_DATA_W-1:0];
        end
    end

    // loaded every cycle, valid one cycle after the last tap lands
    always_ff @(posedge CLK) begin
        result_o <= sum;
    end

endmodule

`default_nettype wire

// File: source/window_buffer.sv
`default_nettype none

`include "cnn_cfg.svh"

module window_buffer
    import cnn_pkg::*;
(
    input  wire logic   CLK,
    input  wire logic   kernel_load_i,
    input  wire logic   window_load_i,
    input  wire tap_t   tap_i,
    input  wire pixel_t rdata_i,
    output pixel_t      kernel_o [`CNN_KERNEL_TAPS],
    output pixel_t      window_o [`CNN_KERNEL_TAPS]
);

    pixel_t kernel_q [`CNN_KERNEL_TAPS];
    pixel_t window_q [`CNN_KERNEL_TAPS];
    logic   tap_ok;

    assign tap_ok = (tap_i < tap_t'(`CNN_KERNEL_TAPS));

    // kernel stays put for the whole layer
    always_ff @(posedge CLK) begin
        if (kernel_load_i && tap_ok) begin
            kernel_q[tap_i] <= rdata_i;
        end
    end

    // refilled per window, pooling only uses taps 0 to 3
    always_ff @(posedge CLK) begin
        if (window_load_i && tap_ok) begin
            window_q[tap_i] <= rdata_i;
        end
    end

    always_comb begin
        for (int i = 0; i < `CNN_KERNEL_TAPS; i++) begin
            kernel_o[i] = kernel_q[i];
            window_o[i] = window_q[i];
        end
    end

endmodule

`default_nettype wire

// File: source/window_addr_gen.sv
`default_nettype none

`include "cnn_cfg.svh"

module window_addr_gen
    import cnn_pkg::*;
(
    input  wire win_pos_t  pos_i,
    input  wire addr_sel_e sel_i,
    input  wire tap_t      tap_i,
    output mem_addr_t      addr_o
);

    mem_addr_t row;
    mem_addr_t col;
    mem_addr_t kernel_base;
    mem_addr_t img_addr;

    // image coordinate of the word being accessed
    always_comb begin
        row = mem_addr_t'(pos_i.row);
        col = mem_addr_t'(pos_i.col);
        case (sel_i)
            CONV_TAP: begin
                row = row + mem_addr_t'(tap_i / 4'd3);
                col = col + mem_addr_t'(tap_i % 4'd3);
            end
            POOL_TAP: begin
                row = row + mem_addr_t'(tap_i / 4'd2);
                col = col + mem_addr_t'(tap_i % 4'd2);
            end
            // pooled block packs into the top-left corner
            POOL_RESULT: begin
                row = row >> 1;
                col = col >> 1;
            end
            default: begin
                row = mem_addr_t'(pos_i.row);
                col = mem_addr_t'(pos_i.col);
            end
        endcase
    end

    assign kernel_base = pos_i.layer ? mem_addr_t'(`CNN_KERNEL2_BASE)
                                     : mem_addr_t'(`CNN_KERNEL1_BASE);

    assign img_addr = mem_addr_t'(`CNN_IMG_BASE) + row * mem_addr_t'(`CNN_ROW_STRIDE) + col;

    assign addr_o = (sel_i == KERNEL_TAP) ? kernel_base + mem_addr_t'(tap_i) : img_addr;

endmodule

`default_nettype wire

// File: common/cnn_pkg.sv
`default_nettype none

`include "cnn_cfg.svh"

package cnn_pkg;

    typedef logic [`CNN_DATA_W-1:0] pixel_t;
    typedef logic [`CNN_ADDR_W-1:0] mem_addr_t;

    // window corner index and tap number
    typedef logic [3:0] pos_t;
    typedef logic [3:0] tap_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_KERNEL,
        CONV_GATHER,
        CONV_WAIT,
        CONV_WRITE,
        POOL_GATHER,
        POOL_WRITE,
        DONE
    } ctrl_state_e;

    typedef enum logic [2:0] {
        KERNEL_TAP,
        CONV_TAP,
        POOL_TAP,
        CONV_RESULT,
        POOL_RESULT
    } addr_sel_e;

    // strobe-and-ack bus request
    typedef struct packed {
        logic      stb;
        logic      we;
        mem_addr_t addr;
        pixel_t    wdata;
    } mem_req_t;

    typedef struct packed {
        logic layer;
        pos_t row;
        pos_t col;
    } win_pos_t;

endpackage

`default_nettype wire

// File: common/cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// word and address widths
`define CNN_DATA_W 16
`define CNN_ADDR_W 8

// taps per window
`define CNN_KERNEL_TAPS 9
`define CNN_POOL_TAPS 4

// memory layout, word addresses
`define CNN_KERNEL1_BASE 0
`define CNN_KERNEL2_BASE 9
`define CNN_IMG_BASE 18
`define CNN_ROW_STRIDE 10

// last top-left index in each direction
`define CNN_L1_CONV_LAST 7
`define CNN_L2_CONV_LAST 1
`define CNN_L1_POOL_LAST 6
`define CNN_L2_POOL_LAST 0

`endif
